/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f filelist.f --top-module tb_vector_unit
	./obj_dir/Vtb_vector_unit > sim.log 2>&1 || (cat sim.log; false)
	cat sim.log
	! grep -q "TEST FAILED" sim.log

clean:
	rm -rf obj_dir sim.log

/* filelist.f */
pkg_tpu.sv
lane_unit.sv
lane_exchange.sv
scalar_reduce.sv
vector_control.sv
vector_unit.sv
tb_clock_gen.sv
tb_vector_unit.sv

/* lane_exchange.sv */
// Cross-lane operand routing
`timescale 1ns/10ps

module lane_exchange
	import pkg_tpu::*;
#(
	parameter int NUM_LANE = pkg_tpu::NUM_LANE
) (
	input data_t lane_src1 [NUM_LANE],	// src1 from each lane
	input xchg_t xchg,					// Routing mode
	output data_t xchg_data [NUM_LANE]	// Operand delivered to each lane
);

	////////////////////
	// Routing
	////////////////////
	always_comb begin
		for (int i = 0; i < NUM_LANE; i++) begin
			case (xchg)
				XCHG_ROT: xchg_data[i] = lane_src1[(i + 1) % NUM_LANE];	// Next lane, wraps
				XCHG_BCAST: xchg_data[i] = lane_src1[0];				// Lane 0 to all
				default: xchg_data[i] = lane_src1[i];					// Own operand
			endcase
		end
	end

endmodule

/* lane_unit.sv */
// Single SIMT lane
`timescale 1ns/10ps

module lane_unit
	import pkg_tpu::*;
#(
	parameter int NUM_LANE = pkg_tpu::NUM_LANE,
	parameter int LANE_ID = 0
) (
	input logic clock,
	input logic rst,
	input reg_idx_t rs1,				// Read index, issue stage
	input reg_idx_t rs2,
	input logic en,						// Lane enabled in execute stage
	input v_opcode_t op,
	input reg_idx_t rd,
	input data_t scalar,
	input data_t xchg_data,				// Routed operand from exchange
	output data_t lane_src1,			// Own src1 toward exchange
	output logic commit					// Writeback this cycle
);

	data_t reg_file [NUM_REG];			// Lane register file
	data_t src1_q;						// Operand stage
	data_t src2_q;
	data_t alu_res;
	logic wr_en;

	// Lane index must fit the array
	if (LANE_ID >= NUM_LANE) begin : g_bad_id
		$error("LANE_ID out of range");
	end

	////////////////////
	// Operand stage
	////////////////////
	always_ff @(posedge clock) begin
		src1_q <= reg_file[rs1];
		src2_q <= reg_file[rs2];
	end

	assign lane_src1 = src1_q;

	////////////////////
	// Execute
	////////////////////
	always_comb begin
		case (op)
			OP_LDI: alu_res = scalar + data_t'(LANE_ID);
			OP_ADD: alu_res = src1_q + src2_q;		// Wraps at 16 bits
			OP_SUB: alu_res = src1_q - src2_q;
			OP_AND: alu_res = src1_q & src2_q;
			OP_XOR: alu_res = src1_q ^ src2_q;
			OP_ROT,
			OP_BCAST: alu_res = xchg_data;			// Cross-lane move
			default: alu_res = src1_q;
		endcase
	end

	// NOP and RSUM commit without touching the file
	assign wr_en = en && (op != OP_RSUM) && (op != OP_NOP);
	assign commit = en;

	always_ff @(posedge clock) begin
		if (rst) begin
			for (int i = 0; i < NUM_REG; i++) begin
				reg_file[i] <= '0;
			end
		end else if (wr_en) begin
			reg_file[rd] <= alu_res;
		end
	end

	////////////////////
	// Checks
	////////////////////
	// Undefined opcodes would write src1 back
	a_op_legal: assert property (@(posedge clock) disable iff (rst)
		en |-> (op <= OP_RSUM))
		else $error("lane enabled with undefined opcode");

endmodule

/* pkg_tpu.sv */
// Vector unit shared types
package pkg_tpu;

	////////////////////
	// Sizing
	////////////////////
	localparam int NUM_LANE = 4;						// Default lane count
	localparam int NUM_REG = 8;						// Registers per lane
	localparam int DATA_W = 16;						// Lane data width
	localparam int REG_IDX_W = $clog2(NUM_REG);		// Register index width

	////////////////////
	// Basic types
	////////////////////
	typedef logic [DATA_W-1:0] data_t;				// One lane data word
	typedef logic [NUM_LANE-1:0] lane_t;			// One bit per lane
	typedef logic [REG_IDX_W-1:0] reg_idx_t;		// Register index

	////////////////////
	// Command encoding
	////////////////////
	typedef enum logic [3:0] {
		OP_NOP = 4'd0,		// No operation
		OP_LDI = 4'd1,		// rd = scalar + lane index
		OP_ADD = 4'd2,		// rd = src1 + src2
		OP_SUB = 4'd3,		// rd = src1 - src2
		OP_AND = 4'd4,		// rd = src1 & src2
		OP_XOR = 4'd5,		// rd = src1 ^ src2
		OP_ROT = 4'd6,		// rd = src1 of next lane
		OP_BCAST = 4'd7,	// rd = src1 of lane 0
		OP_RSUM = 4'd8		// Scalar sum, no write
	} v_opcode_t;

	// Cross-lane routing mode
	typedef enum logic [1:0] {
		XCHG_NONE = 2'd0,	// Own operand
		XCHG_ROT = 2'd1,	// Neighbour operand
		XCHG_BCAST = 2'd2	// Lane 0 operand
	} xchg_t;

endpackage

/* scalar_reduce.sv */
// Masked lane sum reduction
`timescale 1ns/10ps

module scalar_reduce
	import pkg_tpu::*;
#(
	parameter int NUM_LANE = pkg_tpu::NUM_LANE
) (
	input logic clock,
	input logic rst,
	input data_t lane_src1 [NUM_LANE],	// Operands from lanes
	input lane_t mask,					// Lanes taking part
	input logic reduce,					// Capture strobe
	output data_t scalar_out,
	output logic scalar_valid
);

	localparam int LVL = (NUM_LANE > 1) ? $clog2(NUM_LANE) : 1;	// Tree depth
	localparam int LEAF = 1 << LVL;								// Padded leaf count

	data_t leaf [LEAF];					// Masked operands, zero padded
	data_t node [2*LEAF-1];				// Heap order, root at 0

	////////////////////
	// Adder tree
	////////////////////
	for (genvar i = 0; i < LEAF; i++) begin : g_leaf
		if (i < NUM_LANE) begin : g_used
			assign leaf[i] = mask[i] ? lane_src1[i] : '0;
		end else begin : g_pad
			assign leaf[i] = '0;
		end
	end

	always_comb begin
		for (int i = 0; i < LEAF; i++) begin
			node[LEAF-1+i] = leaf[i];
		end
		for (int j = LEAF - 2; j >= 0; j--) begin
			node[j] = node[2*j+1] + node[2*j+2];	// Pairwise, wraps at 16 bits
		end
	end

	always_ff @(posedge clock) begin
		if (reduce) begin
			scalar_out <= node[0];		// Held until next reduction
		end
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			scalar_valid <= 1'b0;
		end else begin
			scalar_valid <= reduce;
		end
	end

	a_reduce_mask: assert property (@(posedge clock) disable iff (rst)
		reduce |-> (mask != '0))
		else $error("reduction with no lane enabled");

endmodule

/* tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/10ps

module tb_clock_gen #(
	parameter int PERIOD = 100,
	parameter int RST_CYCLES = 3
) (
	output logic clock,
	output logic rst
);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;	// 50 ns half period
	end

	initial begin
		rst = 1'b1;								// Held from time zero
		repeat (RST_CYCLES) @(posedge clock);
		rst <= 1'b0;							// Released on third edge
	end

endmodule

/* tb_vector_unit.sv */
// Vector unit testbench
`timescale 1ns/10ps

module tb_vector_unit;
	import pkg_tpu::*;

	logic clock;
	logic rst;
	lane_t en_lane;
	v_opcode_t opcode;
	reg_idx_t rd;
	reg_idx_t rs1;
	reg_idx_t rs2;
	data_t scalar_in;
	data_t scalar_out;
	logic scalar_valid;
	logic commit_req;

	int unsigned c_en [$];				// Case table from file
	int unsigned c_op [$];
	int unsigned c_rd [$];
	int unsigned c_rs1 [$];
	int unsigned c_rs2 [$];
	int unsigned c_scalar [$];
	int unsigned c_flag [$];			// Scalar result expected
	int unsigned c_exp [$];

	int exp_case [$];					// Case index, -1 for idle slot
	bit exp_commit [$];
	bit exp_valid [$];
	data_t exp_scalar [$];

	int errors;
	int checks;
	int done_cases;
	int cycles;
	int limit;							// Timeout in cycles
	bit running;

	tb_clock_gen u_clk (
		.clock(clock),
		.rst(rst)
	);

	vector_unit #(
		.NUM_LANE(NUM_LANE)
	) dut (
		.clock(clock),
		.rst(rst),
		.en_lane(en_lane),
		.opcode(opcode),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.scalar_in(scalar_in),
		.scalar_out(scalar_out),
		.scalar_valid(scalar_valid),
		.commit_req(commit_req)
	);

	////////////////////
	// Helpers
	////////////////////
	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("** Error at %0d ns: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	task automatic load_cases();
		int fd;
		string line;
		int unsigned f_en, f_op, f_rd, f_rs1, f_rs2, f_sc, f_flag, f_exp;
		fd = $fopen("vector_cases.txt", "r");
		if (fd == 0) begin
			$display("cannot open vector_cases.txt");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			// Comment and blank lines scan short
			if ($sscanf(line, "%h %h %h %h %h %h %h %h", f_en, f_op, f_rd, f_rs1,
					f_rs2, f_sc, f_flag, f_exp) == 8) begin
				c_en.push_back(f_en);
				c_op.push_back(f_op);
				c_rd.push_back(f_rd);
				c_rs1.push_back(f_rs1);
				c_rs2.push_back(f_rs2);
				c_scalar.push_back(f_sc);
				c_flag.push_back(f_flag);
				c_exp.push_back(f_exp);
			end
		end
		$fclose(fd);
	endtask

	task automatic push_expect(input int idx, input bit cm, input bit vl, input data_t sc);
		exp_case.push_back(idx);
		exp_commit.push_back(cm);
		exp_valid.push_back(vl);
		exp_scalar.push_back(sc);
	endtask

	task automatic drive_case(input int i);
		en_lane <= lane_t'(c_en[i]);
		opcode <= v_opcode_t'(c_op[i]);
		rd <= reg_idx_t'(c_rd[i]);
		rs1 <= reg_idx_t'(c_rs1[i]);
		rs2 <= reg_idx_t'(c_rs2[i]);
		scalar_in <= data_t'(c_scalar[i]);
		push_expect(i, c_en[i] != 0, c_flag[i] != 0, data_t'(c_exp[i]));	// Any lane set commits
	endtask

	task automatic drive_idle();
		en_lane <= '0;					// Zero mask, no issue
		opcode <= OP_NOP;
		push_expect(-1, 1'b0, 1'b0, '0);
	endtask

	////////////////////
	// Response check
	////////////////////
	// Slot at the front was issued two edges back
	always @(negedge clock) begin : check_slot
		int idx;
		bit want_valid;
		data_t want_scalar;
		int errs_before;
		if (running && exp_case.size() >= 3) begin
			idx = exp_case.pop_front();
			want_valid = exp_valid.pop_front();
			want_scalar = exp_scalar.pop_front();
			errs_before = errors;
			check_value("commit_req", 32'(commit_req), 32'(exp_commit.pop_front()));
			check_value("scalar_valid", 32'(scalar_valid), 32'(want_valid));
			if (want_valid) begin
				check_value("scalar_out", 32'(scalar_out), 32'(want_scalar));
			end
			if (idx >= 0) begin
				done_cases++;
				if (errors == errs_before) begin
					$display("case %0d: ok", idx + 1);
				end else begin
					$display("case %0d: mismatch", idx + 1);
				end
			end
		end
	end

	always @(posedge clock) begin
		if (running) begin
			cycles++;
			if (cycles > limit) begin
				$display("timeout after %0d cycles, %0d cases unchecked", limit,
					c_en.size() - done_cases);
				$display("TEST FAILED");
				$finish;
			end
		end
	end

	////////////////////
	// Stimulus
	////////////////////
	initial begin : main
		en_lane = '0;
		opcode = OP_NOP;
		rd = '0;
		rs1 = '0;
		rs2 = '0;
		scalar_in = '0;
		errors = 0;
		checks = 0;
		done_cases = 0;
		cycles = 0;
		running = 1'b0;
		load_cases();
		if (c_en.size() == 0) begin
			errors++;
			$display("no cases read from vector_cases.txt");
		end
		limit = c_en.size() * 2 + 20;
		@(negedge rst);					// Reset release edge
		push_expect(-1, 1'b0, 1'b0, '0);	// Outputs idle right after reset
		push_expect(-1, 1'b0, 1'b0, '0);
		running = 1'b1;
		for (int i = 0; i < c_en.size(); i++) begin
			@(posedge clock);
			drive_case(i);				// One line per cycle
		end
		while (done_cases < c_en.size()) begin
			@(posedge clock);
			drive_idle();				// Drain the pipe
		end
		$display("cases %0d, checks %0d, errors %0d", done_cases, checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

/* vector_cases.txt */
// en_lane opcode rd rs1 rs2 scalar_in flag expected, all hex
// flag 1 means scalar_out must equal expected two edges after issue
0 0 0 0 0 0000 0 0000
f 8 0 0 0 0000 1 0000
f 1 1 0 0 0010 0 0000
f 1 2 0 0 fffe 0 0000
0 0 0 0 0 0000 0 0000
f 8 0 1 0 0000 1 0046
1 8 0 1 0 0000 1 0010
2 8 0 1 0 0000 1 0011
4 8 0 1 0 0000 1 0012
8 8 0 1 0 0000 1 0013
f 2 3 1 2 0000 0 0000
f 3 4 1 2 0000 0 0000
f 4 5 1 2 0000 0 0000
f 5 6 1 2 0000 0 0000
0 0 0 0 0 0000 0 0000
f 8 0 3 0 0000 1 0044
f 8 0 4 0 0000 1 0048
f 8 0 5 0 0000 1 0022
f 8 0 6 0 0000 1 0000
f 6 7 1 0 0000 0 0000
f 7 0 2 0 0000 0 0000
0 0 0 0 0 0000 0 0000
1 8 0 7 0 0000 1 0011
8 8 0 7 0 0000 1 0010
f 8 0 0 0 0000 1 fff8
5 1 1 0 0 0100 0 0000
0 0 0 0 0 0000 0 0000
f 8 0 1 0 0000 1 0226

/* vector_control.sv */
// Vector command issue and commit
`timescale 1ns/10ps

module vector_control
	import pkg_tpu::*;
#(
	parameter int NUM_LANE = pkg_tpu::NUM_LANE
) (
	input logic clock,
	input logic rst,
	input lane_t en_lane,				// Issue mask
	input v_opcode_t opcode,
	input reg_idx_t rd,
	input reg_idx_t rs1,
	input reg_idx_t rs2,
	input data_t scalar_in,
	output reg_idx_t stage1_rs1,		// Read index to lanes
	output reg_idx_t stage1_rs2,
	output lane_t stage2_en,			// Execute mask
	output v_opcode_t stage2_op,
	output reg_idx_t stage2_rd,
	output data_t stage2_scalar,
	output xchg_t stage2_xchg,
	output logic reduce,				// Reduction in execute stage
	input lane_t lane_commit,			// Writeback pulses from lanes
	output logic commit_req
);

	logic issue;						// Command present this cycle
	xchg_t xchg_dec;					// Decoded exchange mode
	logic reduce_dec;					// Decoded reduction

	////////////////////
	// Stage 1, issue
	////////////////////
	// Register file is read with the raw indices so operands land at the issue edge
	assign issue = |en_lane;
	assign stage1_rs1 = rs1;
	assign stage1_rs2 = rs2;

	always_comb begin
		case (opcode)
			OP_ROT: xchg_dec = XCHG_ROT;		// Take neighbour
			OP_BCAST: xchg_dec = XCHG_BCAST;	// Take lane 0
			default: xchg_dec = XCHG_NONE;
		endcase
	end

	assign reduce_dec = issue && (opcode == OP_RSUM);

	////////////////////
	// Stage 2, execute
	////////////////////
	always_ff @(posedge clock) begin
		if (rst) begin
			stage2_en <= '0;
			reduce <= 1'b0;
		end else begin
			stage2_en <= en_lane;				// Zero mask is a bubble
			reduce <= reduce_dec;
		end
	end

	always_ff @(posedge clock) begin
		stage2_op <= opcode;					// Payload, qualified by mask
		stage2_rd <= rd;
		stage2_scalar <= scalar_in;
		stage2_xchg <= xchg_dec;
	end

	// Commit once every enabled lane has reported writeback
	always_ff @(posedge clock) begin
		if (rst) begin
			commit_req <= 1'b0;
		end else begin
			commit_req <= (|stage2_en) && (lane_commit == stage2_en);
		end
	end

	////////////////////
	// Checks
	////////////////////
	a_commit_src: assert property (@(posedge clock) disable iff (rst)
		commit_req == $past(|stage2_en))
		else $error("commit_req out of step with stage 2 command");

	a_commit_mask: assert property (@(posedge clock) disable iff (rst)
		(lane_commit & ~stage2_en) == '0)
		else $error("lane commit outside stage 2 mask");

endmodule

/* vector_unit.sv */
// SIMT vector unit top
`timescale 1ns/10ps

module vector_unit
	import pkg_tpu::*;
#(
	parameter int NUM_LANE = pkg_tpu::NUM_LANE
) (
	input logic clock,
	input logic rst,
	input lane_t en_lane,				// Lane enable, non-zero issues
	input v_opcode_t opcode,			// Command
	input reg_idx_t rd,					// Destination register
	input reg_idx_t rs1,				// Source register 1
	input reg_idx_t rs2,				// Source register 2
	input data_t scalar_in,				// Scalar operand
	output data_t scalar_out,			// Reduction result
	output logic scalar_valid,			// Reduction result strobe
	output logic commit_req				// All enabled lanes written back
);

	reg_idx_t stage1_rs1;				// Read indices, issue stage
	reg_idx_t stage1_rs2;
	lane_t stage2_en;					// Lane mask, execute stage
	v_opcode_t stage2_op;
	reg_idx_t stage2_rd;
	data_t stage2_scalar;
	xchg_t stage2_xchg;
	logic reduce;						// Reduction strobe
	lane_t lane_commit;					// Per-lane writeback pulses
	data_t lane_src1 [NUM_LANE];		// Registered src1 per lane
	data_t xchg_data [NUM_LANE];		// Routed operand per lane

	////////////////////
	// Issue and commit
	////////////////////
	vector_control #(
		.NUM_LANE(NUM_LANE)
	) u_control (
		.clock(clock),
		.rst(rst),
		.en_lane(en_lane),
		.opcode(opcode),
		.rd(rd),
		.rs1(rs1),
		.rs2(rs2),
		.scalar_in(scalar_in),
		.stage1_rs1(stage1_rs1),
		.stage1_rs2(stage1_rs2),
		.stage2_en(stage2_en),
		.stage2_op(stage2_op),
		.stage2_rd(stage2_rd),
		.stage2_scalar(stage2_scalar),
		.stage2_xchg(stage2_xchg),
		.reduce(reduce),
		.lane_commit(lane_commit),
		.commit_req(commit_req)
	);

	////////////////////
	// Lane array
	////////////////////
	for (genvar i = 0; i < NUM_LANE; i++) begin : g_lane
		lane_unit #(
			.NUM_LANE(NUM_LANE),
			.LANE_ID(i)
		) u_lane (
			.clock(clock),
			.rst(rst),
			.rs1(stage1_rs1),
			.rs2(stage1_rs2),
			.en(stage2_en[i]),
			.op(stage2_op),
			.rd(stage2_rd),
			.scalar(stage2_scalar),
			.xchg_data(xchg_data[i]),
			.lane_src1(lane_src1[i]),
			.commit(lane_commit[i])
		);
	end

	lane_exchange #(
		.NUM_LANE(NUM_LANE)
	) u_exchange (
		.lane_src1(lane_src1),
		.xchg(stage2_xchg),
		.xchg_data(xchg_data)
	);

	scalar_reduce #(
		.NUM_LANE(NUM_LANE)
	) u_reduce (
		.clock(clock),
		.rst(rst),
		.lane_src1(lane_src1),
		.mask(stage2_en),
		.reduce(reduce),
		.scalar_out(scalar_out),
		.scalar_valid(scalar_valid)
	);

endmodule
